// ==== rtl/mempool_lite_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, memory map, response and target enums, and the internal
// memory request and response structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mempool_lite_pkg;

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = 4;
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 64;
  localparam int unsigned L2Size         = 1024;
  localparam int unsigned NumCores       = 4;

  // Bank index sits right above the byte offset and the row above that
  localparam int unsigned L2BankIdxWidth = $clog2(NumL2Banks);
  localparam int unsigned L2RowWidth     = $clog2(L2BankNumWords);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Memory map ranges include the start and exclude the end
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t L2EndAddr       = L2BaseAddr + addr_t'(L2Size);
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA001_0000;
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4001_0000;

  localparam int unsigned BootromNumWords = 16;
  localparam int unsigned BootromIdxWidth = $clog2(BootromNumWords);
  localparam data_t       BootromWordBase = 32'hB007_0000;

  localparam addr_t CtrlEocOffset      = 32'h0;
  localparam addr_t CtrlWakeUpOffset   = 32'h4;
  localparam addr_t CtrlL2SizeOffset   = 32'h8;
  localparam addr_t CtrlNumCoresOffset = 32'hC;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axil_resp_e;

  typedef enum logic [1:0] {
    TgtCtrl,
    TgtBootrom,
    TgtL2,
    TgtNone
  } target_e;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

endpackage

// ==== rtl/axil_slave_port.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave with a single outstanding transaction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module axil_slave_port
  import mempool_lite_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  addr_t      aw_addr_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  input  data_t      w_data_i,
  input  strb_t      w_strb_i,
  output logic       b_valid_o,
  input  logic       b_ready_i,
  output axil_resp_e b_resp_o,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  input  addr_t      ar_addr_i,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  output data_t      r_data_o,
  output axil_resp_e r_resp_o,
  output logic       req_valid_o,
  output mem_req_t   req_o,
  input  logic       rsp_valid_i,
  input  mem_rsp_t   rsp_i
);

  typedef enum logic [1:0] {
    Idle,
    Issue,
    Wait,
    Respond
  } state_e;

  state_e   state_q;
  logic     is_write_q;
  mem_req_t req_q;
  mem_rsp_t rsp_q;

  // AW and W go together, and a waiting write blocks AR
  assign aw_ready_o = (state_q == Idle) && aw_valid_i && w_valid_i;
  assign w_ready_o  = aw_ready_o;
  assign ar_ready_o = (state_q == Idle) && !aw_valid_i && !w_valid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= Idle;
      is_write_q <= 1'b0;
    end else begin
      unique case (state_q)
        Idle: begin
          if (aw_ready_o) begin
            is_write_q <= 1'b1;
            state_q    <= Issue;
          end else if (ar_valid_i && ar_ready_o) begin
            is_write_q <= 1'b0;
            state_q    <= Issue;
          end
        end
        Issue: state_q <= Wait;
        Wait: begin
          if (rsp_valid_i) begin
            state_q <= Respond;
          end
        end
        Respond: begin
          if (is_write_q ? b_ready_i : r_ready_i) begin
            state_q <= Idle;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (aw_ready_o) begin
      req_q <= '{we: 1'b1, addr: aw_addr_i, wdata: w_data_i, strb: w_strb_i};
    end else if (ar_valid_i && ar_ready_o) begin
      req_q <= '{we: 1'b0, addr: ar_addr_i, wdata: '0, strb: '0};
    end
    if (state_q == Wait && rsp_valid_i) begin
      rsp_q <= rsp_i;
    end
  end

  assign req_valid_o = (state_q == Issue);
  assign req_o       = req_q;

  assign b_valid_o = (state_q == Respond) && is_write_q;
  assign r_valid_o = (state_q == Respond) && !is_write_q;
  assign b_resp_o  = rsp_q.err ? RespSlvErr : RespOkay;
  assign r_resp_o  = rsp_q.err ? RespSlvErr : RespOkay;
  assign r_data_o  = rsp_q.rdata;

  assert property (@(posedge clk_i) disable iff (rst_i) !(b_valid_o && r_valid_o))
    else $error("B and R valid in the same cycle");

endmodule

// ==== rtl/addr_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder for L2, boot ROM and control registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module addr_decoder
  import mempool_lite_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     req_valid_i,
  input  mem_req_t req_i,
  output logic     l2_valid_o,
  output logic     rom_valid_o,
  output logic     ctrl_valid_o,
  output mem_req_t tgt_req_o,
  input  mem_rsp_t l2_rsp_i,
  input  mem_rsp_t rom_rsp_i,
  input  mem_rsp_t ctrl_rsp_i,
  output logic     rsp_valid_o,
  output mem_rsp_t rsp_o
);

  target_e tgt_d, tgt_q;
  logic    valid_q;

  always_comb begin
    if (req_i.addr >= CtrlBaseAddr && req_i.addr < CtrlEndAddr) begin
      tgt_d = TgtCtrl;
    end else if (req_i.addr >= BootromBaseAddr && req_i.addr < BootromEndAddr) begin
      // ROM writes fall through to the error path
      tgt_d = req_i.we ? TgtNone : TgtBootrom;
    end else if (req_i.addr >= L2BaseAddr && req_i.addr < L2EndAddr) begin
      tgt_d = TgtL2;
    end else begin
      tgt_d = TgtNone;
    end
  end

  assign tgt_req_o    = req_i;
  assign l2_valid_o   = req_valid_i && (tgt_d == TgtL2);
  assign rom_valid_o  = req_valid_i && (tgt_d == TgtBootrom);
  assign ctrl_valid_o = req_valid_i && (tgt_d == TgtCtrl);

  // Remember the target to steer the response back
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      tgt_q   <= TgtNone;
    end else begin
      valid_q <= req_valid_i;
      if (req_valid_i) begin
        tgt_q <= tgt_d;
      end
    end
  end

  assign rsp_valid_o = valid_q;

  always_comb begin
    unique case (tgt_q)
      TgtCtrl:    rsp_o = ctrl_rsp_i;
      TgtBootrom: rsp_o = rom_rsp_i;
      TgtL2:      rsp_o = l2_rsp_i;
      default:    rsp_o = '{rdata: '0, err: 1'b1};
    endcase
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({l2_valid_o, rom_valid_o, ctrl_valid_o}))
    else $error("More than one target selected");

endmodule

// ==== rtl/l2_banked_mem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-interleaved L2 with four single-port banks and byte strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module l2_banked_mem
  import mempool_lite_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  logic [L2BankIdxWidth-1:0] bank_sel;
  logic [L2BankIdxWidth-1:0] bank_sel_q;
  logic [L2RowWidth-1:0]     row;
  logic [NumL2Banks-1:0]     bank_en;
  data_t [NumL2Banks-1:0]    bank_rdata;

  // Bank bits are cut out and the row comes from the bits above them
  assign bank_sel = req_i.addr[2 +: L2BankIdxWidth];
  assign row      = req_i.addr[2 + L2BankIdxWidth +: L2RowWidth];

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_banks
    data_t mem_q [L2BankNumWords];
    data_t rdata_q;

    assign bank_en[b] = valid_i && (bank_sel == b);

    always_ff @(posedge clk_i) begin
      if (bank_en[b]) begin
        if (req_i.we) begin
          for (int i = 0; i < StrbWidth; i++) begin
            if (req_i.strb[i]) begin
              mem_q[row][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
            end
          end
        end else begin
          rdata_q <= mem_q[row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Selected bank of the previous request drives the response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bank_sel_q <= '0;
    end else if (valid_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign rsp_o = '{rdata: bank_rdata[bank_sel_q], err: 1'b0};

  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(bank_en))
    else $error("More than one L2 bank enabled");

endmodule

// ==== rtl/bootrom.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot ROM table with a registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module bootrom
  import mempool_lite_pkg::*;
(
  input  logic  clk_i,
  input  logic  valid_i,
  input  addr_t addr_i,
  output data_t rdata_o
);

  data_t [BootromNumWords-1:0] rom_table;
  logic  [BootromIdxWidth-1:0] idx;
  data_t                       rdata_q;

  // Word i holds the base pattern plus its index
  for (genvar i = 0; i < BootromNumWords; i++) begin : gen_table
    assign rom_table[i] = BootromWordBase + data_t'(i);
  end

  // Contents repeat through the whole range
  assign idx = addr_i[2 +: BootromIdxWidth];

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rdata_q <= rom_table[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== rtl/ctrl_registers.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// End-of-computation, wake-up and identification registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ctrl_registers
  import mempool_lite_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                valid_i,
  input  mem_req_t            req_i,
  output mem_rsp_t            rsp_o,
  output logic                eoc_valid_o,
  output logic [NumCores-1:0] wake_up_o
);

  addr_t               offset;
  data_t               eoc_q;
  logic [NumCores-1:0] wake_q;
  data_t               rdata_q;

  assign offset = req_i.addr - CtrlBaseAddr;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q  <= '0;
      wake_q <= '0;
    end else begin
      // Wake-up lines only pulse for one cycle
      wake_q <= '0;
      if (valid_i && req_i.we) begin
        if (offset == CtrlEocOffset) begin
          for (int i = 0; i < StrbWidth; i++) begin
            if (req_i.strb[i]) begin
              eoc_q[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
            end
          end
        end else if (offset == CtrlWakeUpOffset) begin
          wake_q <= req_i.wdata[NumCores-1:0];
        end
      end
    end
  end

  // Wake-up and unknown offsets read as zero
  always_ff @(posedge clk_i) begin
    if (valid_i && !req_i.we) begin
      unique case (offset)
        CtrlEocOffset:      rdata_q <= eoc_q;
        CtrlL2SizeOffset:   rdata_q <= data_t'(L2Size);
        CtrlNumCoresOffset: rdata_q <= data_t'(NumCores);
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o       = '{rdata: rdata_q, err: 1'b0};
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(valid_i && req_i.we && offset == CtrlWakeUpOffset) |-> wake_up_o == '0)
    else $error("Wake-up pulse without a preceding wake-up write");

endmodule

// ==== rtl/mempool_lite_system.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level with the host port, the decoder and the three targets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mempool_lite_system
  import mempool_lite_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  addr_t               aw_addr_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  data_t               w_data_i,
  input  strb_t               w_strb_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axil_resp_e          b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  addr_t               ar_addr_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output data_t               r_data_o,
  output axil_resp_e          r_resp_o,
  output logic                eoc_valid_o,
  output logic [NumCores-1:0] wake_up_o
);

  logic     req_valid, rsp_valid;
  mem_req_t req, tgt_req;
  mem_rsp_t rsp, l2_rsp, rom_rsp, ctrl_rsp;
  logic     l2_valid, rom_valid, ctrl_valid;
  data_t    rom_rdata;

  axil_slave_port i_axil_slave_port (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .aw_valid_i (aw_valid_i ),
    .aw_ready_o (aw_ready_o ),
    .aw_addr_i  (aw_addr_i  ),
    .w_valid_i  (w_valid_i  ),
    .w_ready_o  (w_ready_o  ),
    .w_data_i   (w_data_i   ),
    .w_strb_i   (w_strb_i   ),
    .b_valid_o  (b_valid_o  ),
    .b_ready_i  (b_ready_i  ),
    .b_resp_o   (b_resp_o   ),
    .ar_valid_i (ar_valid_i ),
    .ar_ready_o (ar_ready_o ),
    .ar_addr_i  (ar_addr_i  ),
    .r_valid_o  (r_valid_o  ),
    .r_ready_i  (r_ready_i  ),
    .r_data_o   (r_data_o   ),
    .r_resp_o   (r_resp_o   ),
    .req_valid_o(req_valid  ),
    .req_o      (req        ),
    .rsp_valid_i(rsp_valid  ),
    .rsp_i      (rsp        )
  );

  addr_decoder i_addr_decoder (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .req_valid_i (req_valid ),
    .req_i       (req       ),
    .l2_valid_o  (l2_valid  ),
    .rom_valid_o (rom_valid ),
    .ctrl_valid_o(ctrl_valid),
    .tgt_req_o   (tgt_req   ),
    .l2_rsp_i    (l2_rsp    ),
    .rom_rsp_i   (rom_rsp   ),
    .ctrl_rsp_i  (ctrl_rsp  ),
    .rsp_valid_o (rsp_valid ),
    .rsp_o       (rsp       )
  );

  l2_banked_mem i_l2_banked_mem (
    .clk_i  (clk_i   ),
    .rst_i  (rst_i   ),
    .valid_i(l2_valid),
    .req_i  (tgt_req ),
    .rsp_o  (l2_rsp  )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i       ),
    .valid_i(rom_valid   ),
    .addr_i (tgt_req.addr),
    .rdata_o(rom_rdata   )
  );

  // ROM never flags an error itself
  assign rom_rsp = '{rdata: rom_rdata, err: 1'b0};

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .valid_i    (ctrl_valid ),
    .req_i      (tgt_req    ),
    .rsp_o      (ctrl_rsp   ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and synchronous reset generator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 4 ns period
  localparam int HalfPeriod  = 2;
  localparam int ResetCycles = 10;

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

  always #(HalfPeriod) clk_o = ~clk_o;

endmodule

// ==== testbench/tb_mempool_lite_system.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory map top level with an L2 and register model,
// random stimulus, back-pressure checks and a cycle timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_mempool_lite_system
  import mempool_lite_pkg::*;
();

  localparam int NumL2Writes   = 200;
  localparam int ReadsPerWrite = 2;
  localparam int NumRomReads   = 16;
  localparam int NumCtrlTxns   = 7;
  localparam int NumDecodeErr  = 20;
  localparam int NumBackPress  = 20;
  localparam int NumTxns       = NumL2Writes * (1 + ReadsPerWrite) + 2 * NumL2Banks
                               + NumRomReads + 1 + NumCtrlTxns
                               + 2 * NumDecodeErr + 2 * NumBackPress;
  localparam int TimeoutCycles = NumTxns * 12 + 50;
  localparam int L2NumWords    = L2Size / 4;

  logic                clk, rst;
  logic                aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic                ar_valid, ar_ready, r_valid, r_ready;
  addr_t               aw_addr, ar_addr;
  data_t               w_data, r_data;
  strb_t               w_strb;
  axil_resp_e          b_resp, r_resp;
  logic                eoc_valid;
  logic [NumCores-1:0] wake_up;

  // Reference model of the L2 with the bytes that have been written
  data_t l2_model [L2NumWords];
  strb_t l2_known [L2NumWords];
  addr_t written_addrs [$];

  string               test_name;
  int                  test_errors  = 0;
  int                  error_count  = 0;
  int                  tests_passed = 0;
  int                  tests_failed = 0;
  int                  cycle_count  = 0;
  int                  wake_pulses  = 0;
  logic [NumCores-1:0] wake_seen    = '0;

  tb_clock_gen clock_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  mempool_lite_system DUT (
    .clk_i      (clk      ),
    .rst_i      (rst      ),
    .aw_valid_i (aw_valid ),
    .aw_ready_o (aw_ready ),
    .aw_addr_i  (aw_addr  ),
    .w_valid_i  (w_valid  ),
    .w_ready_o  (w_ready  ),
    .w_data_i   (w_data   ),
    .w_strb_i   (w_strb   ),
    .b_valid_o  (b_valid  ),
    .b_ready_i  (b_ready  ),
    .b_resp_o   (b_resp   ),
    .ar_valid_i (ar_valid ),
    .ar_ready_o (ar_ready ),
    .ar_addr_i  (ar_addr  ),
    .r_valid_o  (r_valid  ),
    .r_ready_i  (r_ready  ),
    .r_data_o   (r_data   ),
    .r_resp_o   (r_resp   ),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Test failed");
      $finish;
    end
  end

  // Wake-up pulses are short, so they are counted as they appear
  always @(negedge clk) begin
    if (wake_up != '0) begin
      wake_seen   <= wake_up;
      wake_pulses <= wake_pulses + 1;
    end
  end

  function automatic data_t strb_mask(strb_t strb);
    data_t mask;
    for (int i = 0; i < StrbWidth; i++) begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  function automatic bit in_mapped_range(addr_t addr);
    return (addr >= CtrlBaseAddr && addr < CtrlEndAddr)
        || (addr >= BootromBaseAddr && addr < BootromEndAddr)
        || (addr >= L2BaseAddr && addr < L2EndAddr);
  endfunction

  function automatic addr_t random_l2_addr();
    return L2BaseAddr + addr_t'(($urandom % L2NumWords) * 4);
  endfunction

  function automatic addr_t random_unmapped_addr();
    addr_t addr;
    addr = $urandom & 32'hFFFF_FFFC;
    while (in_mapped_range(addr)) begin
      addr = $urandom & 32'hFFFF_FFFC;
    end
    return addr;
  endfunction

  function automatic void model_write(addr_t addr, data_t data, strb_t strb);
    int    idx;
    data_t mask;
    idx           = int'((addr - L2BaseAddr) >> 2);
    mask          = strb_mask(strb);
    l2_model[idx] = (l2_model[idx] & ~mask) | (data & mask);
    l2_known[idx] = l2_known[idx] | strb;
  endfunction

  task automatic report_mismatch(input string what, input data_t expected, input data_t actual);
    $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic check_resp(input string what, input axil_resp_e expected,
                            input axil_resp_e actual);
    if (actual != expected) begin
      report_mismatch(what, data_t'(expected), data_t'(actual));
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("[PASS] %s", test_name);
      tests_passed++;
    end else begin
      $display("[FAIL] %s with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    error_count += test_errors;
  endtask

  // Holds B or R for a number of cycles while stray requests knock on the port
  task automatic take_response(input bit is_write, input int hold_cycles);
    logic [37:0] held;
    held = {b_valid, b_resp, r_valid, r_resp, r_data};
    for (int i = 0; i < hold_cycles; i++) begin
      aw_valid = (i % 2 == 0);
      w_valid  = (i % 2 == 0);
      ar_valid = (i % 2 == 1);
      #1;
      if (aw_ready || w_ready || ar_ready) begin
        report_failure("a new request was accepted while a response waited");
      end
      @(negedge clk);
      if ({b_valid, b_resp, r_valid, r_resp, r_data} !== held) begin
        report_failure("the response changed while the host held ready low");
      end
    end
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    ar_valid = 1'b0;
    b_ready  = is_write;
    r_ready  = !is_write;
    @(negedge clk);
    b_ready = 1'b0;
    r_ready = 1'b0;
    if (b_valid || r_valid) begin
      report_failure("the response stayed valid after its transfer");
    end
  endtask

  task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb,
                           input int hold_cycles, output axil_resp_e resp);
    @(negedge clk);
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    aw_addr  = addr;
    w_data   = data;
    w_strb   = strb;
    #1;
    while (!aw_ready) begin
      @(negedge clk);
      #1;
    end
    if (w_ready !== aw_ready) begin
      report_failure("w_ready_o and aw_ready_o differ at the write handshake");
    end
    @(negedge clk);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    while (!b_valid) begin
      @(negedge clk);
    end
    resp = b_resp;
    take_response(1'b1, hold_cycles);
  endtask

  task automatic read_txn(input addr_t addr, input int hold_cycles,
                          output data_t data, output axil_resp_e resp);
    @(negedge clk);
    ar_valid = 1'b1;
    ar_addr  = addr;
    #1;
    while (!ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ar_valid = 1'b0;
    while (!r_valid) begin
      @(negedge clk);
    end
    data = r_data;
    resp = r_resp;
    take_response(1'b0, hold_cycles);
  endtask

  // Only bytes that were written before are compared
  task automatic check_l2_read(input addr_t addr, input data_t rdata, input axil_resp_e resp);
    int    idx;
    data_t mask;
    idx  = int'((addr - L2BaseAddr) >> 2);
    mask = strb_mask(l2_known[idx]);
    if (resp != RespOkay) begin
      report_mismatch($sformatf("read resp at %h", addr), data_t'(RespOkay), data_t'(resp));
    end
    if ((rdata & mask) !== (l2_model[idx] & mask)) begin
      report_mismatch($sformatf("read at %h", addr), l2_model[idx] & mask, rdata & mask);
    end
  endtask

  task automatic test_l2_write_read();
    addr_t      addr;
    data_t      data, rdata;
    strb_t      strb;
    axil_resp_e resp;
    start_test("l2_write_read");
    for (int n = 0; n < NumL2Writes; n++) begin
      addr = random_l2_addr();
      data = $urandom;
      strb = strb_t'($urandom % 15 + 1);
      write_txn(addr, data, strb, 0, resp);
      model_write(addr, data, strb);
      written_addrs.push_back(addr);
      if (resp != RespOkay) begin
        report_mismatch("write resp", data_t'(RespOkay), data_t'(resp));
      end
      for (int r = 0; r < ReadsPerWrite; r++) begin
        addr = written_addrs[$urandom % written_addrs.size()];
        read_txn(addr, 0, rdata, resp);
        check_l2_read(addr, rdata, resp);
      end
    end
    finish_test();
  endtask

  task automatic test_bank_interleave();
    addr_t      base;
    data_t      data, rdata;
    axil_resp_e resp;
    start_test("bank_interleave");
    base = L2BaseAddr + addr_t'(($urandom % L2BankNumWords) * 16);
    for (int b = 0; b < NumL2Banks; b++) begin
      data = $urandom;
      write_txn(base + addr_t'(b * 4), data, 4'hF, 0, resp);
      model_write(base + addr_t'(b * 4), data, 4'hF);
      if (resp != RespOkay) begin
        report_mismatch("write resp", data_t'(RespOkay), data_t'(resp));
      end
    end
    for (int b = NumL2Banks - 1; b >= 0; b--) begin
      read_txn(base + addr_t'(b * 4), 0, rdata, resp);
      check_l2_read(base + addr_t'(b * 4), rdata, resp);
    end
    finish_test();
  endtask

  task automatic test_bootrom();
    addr_t      addr;
    data_t      rdata, expected;
    axil_resp_e resp;
    start_test("bootrom");
    for (int n = 0; n < NumRomReads; n++) begin
      addr     = BootromBaseAddr + (($urandom % 32'h1_0000) & 32'hFFFC);
      expected = BootromWordBase + data_t'(addr[5:2]);
      read_txn(addr, 0, rdata, resp);
      if (resp != RespOkay) begin
        report_mismatch("read resp", data_t'(RespOkay), data_t'(resp));
      end
      if (rdata !== expected) begin
        report_mismatch($sformatf("read at %h", addr), expected, rdata);
      end
    end
    write_txn(BootromBaseAddr, $urandom, 4'hF, 0, resp);
    if (resp != RespSlvErr) begin
      report_mismatch("write resp", data_t'(RespSlvErr), data_t'(resp));
    end
    finish_test();
  endtask

  task automatic test_ctrl_registers();
    data_t      rdata, wake_data;
    axil_resp_e resp;
    int         pulses_before;
    start_test("ctrl_registers");
    write_txn(CtrlBaseAddr + CtrlEocOffset, 32'h1, 4'hF, 0, resp);
    check_resp("EOC write resp", RespOkay, resp);
    if (eoc_valid !== 1'b1) begin
      report_failure("eoc_valid_o did not rise after writing 1 to EOC");
    end
    read_txn(CtrlBaseAddr + CtrlEocOffset, 0, rdata, resp);
    check_resp("EOC read resp", RespOkay, resp);
    if (rdata !== 32'h1) begin
      report_mismatch("EOC read", 32'h1, rdata);
    end
    wake_data     = $urandom % 15 + 1;
    pulses_before = wake_pulses;
    write_txn(CtrlBaseAddr + CtrlWakeUpOffset, wake_data, 4'hF, 0, resp);
    check_resp("wake-up write resp", RespOkay, resp);
    if (wake_pulses - pulses_before != 1) begin
      report_mismatch("wake-up pulse cycles", 32'd1, data_t'(wake_pulses - pulses_before));
    end
    if (wake_seen !== wake_data[NumCores-1:0]) begin
      report_mismatch("wake-up lines", wake_data & 32'hF, data_t'(wake_seen));
    end
    if (wake_up !== '0) begin
      report_failure("wake_up_o did not return to zero");
    end
    read_txn(CtrlBaseAddr + CtrlWakeUpOffset, 0, rdata, resp);
    check_resp("wake-up read resp", RespOkay, resp);
    if (rdata !== '0) begin
      report_mismatch("wake-up read", '0, rdata);
    end
    read_txn(CtrlBaseAddr + CtrlL2SizeOffset, 0, rdata, resp);
    check_resp("L2_SIZE read resp", RespOkay, resp);
    if (rdata !== 32'd1024) begin
      report_mismatch("L2_SIZE read", 32'd1024, rdata);
    end
    read_txn(CtrlBaseAddr + CtrlNumCoresOffset, 0, rdata, resp);
    check_resp("NUM_CORES read resp", RespOkay, resp);
    if (rdata !== 32'd4) begin
      report_mismatch("NUM_CORES read", 32'd4, rdata);
    end
    write_txn(CtrlBaseAddr + CtrlEocOffset, 32'h0, 4'hF, 0, resp);
    check_resp("EOC clear resp", RespOkay, resp);
    if (eoc_valid !== 1'b0) begin
      report_failure("eoc_valid_o did not fall after clearing EOC");
    end
    finish_test();
  endtask

  task automatic test_decode_error();
    addr_t      addr;
    data_t      rdata;
    axil_resp_e resp;
    start_test("decode_error");
    for (int n = 0; n < NumDecodeErr; n++) begin
      addr = random_unmapped_addr();
      read_txn(addr, 0, rdata, resp);
      if (resp != RespSlvErr) begin
        report_mismatch($sformatf("read resp at %h", addr), data_t'(RespSlvErr), data_t'(resp));
      end
      if (rdata !== '0) begin
        report_mismatch($sformatf("read data at %h", addr), '0, rdata);
      end
      addr = random_unmapped_addr();
      write_txn(addr, $urandom, 4'hF, 0, resp);
      if (resp != RespSlvErr) begin
        report_mismatch($sformatf("write resp at %h", addr), data_t'(RespSlvErr), data_t'(resp));
      end
    end
    finish_test();
  endtask

  task automatic test_back_pressure();
    addr_t      addr;
    data_t      data, rdata;
    strb_t      strb;
    axil_resp_e resp;
    start_test("back_pressure");
    for (int n = 0; n < NumBackPress; n++) begin
      addr = random_l2_addr();
      data = $urandom;
      strb = strb_t'($urandom % 15 + 1);
      write_txn(addr, data, strb, int'($urandom % 6), resp);
      model_write(addr, data, strb);
      if (resp != RespOkay) begin
        report_mismatch("write resp", data_t'(RespOkay), data_t'(resp));
      end
      read_txn(addr, int'($urandom % 6), rdata, resp);
      check_l2_read(addr, rdata, resp);
    end
    finish_test();
  endtask

  initial begin
    void'($urandom(32'hee68));
    aw_valid = 1'b0;
    aw_addr  = '0;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar_addr  = '0;
    r_ready  = 1'b0;
    for (int i = 0; i < L2NumWords; i++) begin
      l2_model[i] = '0;
      l2_known[i] = '0;
    end
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end

    test_l2_write_read();
    test_bank_interleave();
    test_bootrom();
    test_ctrl_registers();
    test_decode_error();
    test_back_pressure();

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/mempool_lite_pkg.sv
rtl/axil_slave_port.sv
rtl/addr_decoder.sv
rtl/l2_banked_mem.sv
rtl/bootrom.sv
rtl/ctrl_registers.sv
rtl/mempool_lite_system.sv
testbench/tb_clock_gen.sv
testbench/tb_mempool_lite_system.sv

// ==== run_verilator.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_mempool_lite_system

status=0
./obj_dir/Vtb_mempool_lite_system > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "Test completed successfully" sim.log; then
  exit 0
fi
exit 1
